/* common/fetch_pkg.sv */
// Fetch front end definitions
// Datapath widths, address steps, credit depths and aligner states
package fetch_pkg;

  // ==================================================
  // Datapath widths
  // ==================================================
  localparam int unsigned XLEN        = 32;
  localparam int unsigned WORD_BITS   = 32;
  localparam int unsigned PARCEL_BITS = 16;

  // Address step after one instruction
  localparam int unsigned PC_INC_COMPRESSED = 2;
  localparam int unsigned PC_INC_FULL       = 4;

  // First fetch address out of reset
  localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

  // ==================================================
  // Flow control
  // ==================================================
  // Decoder credits held after reset
  localparam int unsigned DEC_CREDITS = 4;
  // Counter width, covers DEC_CREDITS and WORD_SLOTS
  localparam int unsigned CREDIT_BITS = 3;

  // Aligner word buffer depth, a power of two
  localparam int unsigned WORD_SLOTS = 2;
  localparam int unsigned SLOT_BITS  = $clog2(WORD_SLOTS);

  // Aligner parcel position
  typedef enum logic [1:0] {
    // No partial instruction, next parcel at address bit 1 clear
    ALIGN_IDLE,
    // Next parcel sits in the upper half of the head word
    ALIGN_HI_HALF,
    // Lower half of a 32-bit instruction held, upper half in next word
    ALIGN_SPAN
  } align_state_t;

endpackage

/* common/predict_pkg.sv */
// Branch target buffer definitions
// BTB geometry, entry layout and the PC split into index and tag
package predict_pkg;

  localparam int unsigned BTB_ENTRIES    = 16;
  // Index from PC bits 4 to 1, bit 0 is always clear
  localparam int unsigned BTB_INDEX_BITS = 4;
  localparam int unsigned BTB_TAG_BITS   = fetch_pkg::XLEN - 5;

  typedef logic [BTB_TAG_BITS-1:0]    btb_tag_t;
  typedef logic [fetch_pkg::XLEN-1:0] btb_target_t;

  // One BTB line
  typedef struct packed {
    logic        valid;
    btb_tag_t    tag;
    btb_target_t target;
  } btb_entry_t;

  // Direct-mapped index
  function automatic logic [BTB_INDEX_BITS-1:0] btb_index(
    input logic [fetch_pkg::XLEN-1:0] pc
  );
    return pc[BTB_INDEX_BITS:1];
  endfunction

  // Tag is everything above the index
  function automatic btb_tag_t btb_tag(input logic [fetch_pkg::XLEN-1:0] pc);
    return pc[fetch_pkg::XLEN-1:BTB_INDEX_BITS+1];
  endfunction

endpackage

/* common/fetch_ifs.sv */
// Fetch front end bundles
// Word delivery, head instruction with prediction, and BTB update
`timescale 1ns/10ps

// Memory words from sequencer to aligner, credits back
interface fetch_word_if;
  import fetch_pkg::*;

  logic                 word_valid;
  // Bit 1 marks the start halfword of the first word after a redirect
  logic [XLEN-1:0]      word_addr;
  logic [WORD_BITS-1:0] word_data;
  logic                 flush;
  // One pulse per freed buffer slot
  logic                 word_credit;

  modport sequencer (output word_valid, word_addr, word_data, flush, input word_credit);
  modport aligner (input word_valid, word_addr, word_data, flush, output word_credit);
endinterface

// Oldest whole instruction, seen by BTB and sequencer together
interface fetch_head_if;
  import fetch_pkg::*;

  logic                 head_valid;
  logic [XLEN-1:0]      head_pc;
  logic [WORD_BITS-1:0] head_instr;
  logic                 head_compressed;
  logic                 head_take;
  logic                 pred_hit;
  logic [XLEN-1:0]      pred_target;

  modport aligner (output head_valid, head_pc, head_instr, head_compressed, input head_take);
  modport predictor (input head_pc, output pred_hit, pred_target);
  modport sequencer (
    input  head_valid, head_pc, head_instr, head_compressed, pred_hit, pred_target,
    output head_take
  );
endinterface

// Resolved branch info from execute
interface btb_update_if;
  import fetch_pkg::*;
  import predict_pkg::*;

  logic                      update;
  logic [XLEN-1:0]           pc;
  logic [XLEN-1:0]           target;
  logic                      taken;
  logic [BTB_INDEX_BITS-1:0] wr_index;
  btb_entry_t                wr_entry;

  // Not taken builds an invalid line, written only over a matching tag
  assign wr_index = btb_index(pc);
  assign wr_entry = '{valid: taken, tag: btb_tag(pc), target: target};

  modport predictor (input update, wr_index, wr_entry);
endinterface

/* btb/btb_predictor.sv */
// Branch target buffer
// Direct-mapped lookup on the head instruction, written by execute updates
`timescale 1ns/10ps

module btb_predictor (
  input logic             i_clk,
  input logic             i_rst_n,
  fetch_head_if.predictor head,
  btb_update_if.predictor upd
);
  import predict_pkg::*;

  // Storage, only the valid bits see reset
  logic [BTB_ENTRIES-1:0] valid_q;
  btb_tag_t               tag_q    [BTB_ENTRIES];
  btb_target_t            target_q [BTB_ENTRIES];

  // Lookup side
  logic [BTB_INDEX_BITS-1:0] rd_index;
  btb_entry_t                rd_entry;

  // Update side
  logic upd_match;
  logic upd_write;

  // ==================================================
  // Lookup
  // ==================================================
  assign rd_index = btb_index(head.head_pc);

  assign rd_entry = '{
    valid:  valid_q[rd_index],
    tag:    tag_q[rd_index],
    target: target_q[rd_index]
  };

  // Hit only on a full tag compare, no partial tags
  assign head.pred_hit    = rd_entry.valid && (rd_entry.tag == btb_tag(head.head_pc));
  assign head.pred_target = rd_entry.target;

  // ==================================================
  // Update
  // ==================================================
  // Existing line for the same branch
  assign upd_match = valid_q[upd.wr_index] && (tag_q[upd.wr_index] == upd.wr_entry.tag);

  // Taken always allocates and evicts any alias
  // Not taken only kills its own line
  assign upd_write = upd.update && (upd.wr_entry.valid || upd_match);

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      valid_q <= '0;
    end else if (upd_write) begin
      valid_q[upd.wr_index] <= upd.wr_entry.valid;
    end
  end

  // Tag and target follow the valid bit
  always_ff @(posedge i_clk) begin
    if (upd_write) begin
      tag_q[upd.wr_index]    <= upd.wr_entry.tag;
      target_q[upd.wr_index] <= upd.wr_entry.target;
    end
  end

endmodule

/* aligner/instruction_aligner.sv */
// Instruction aligner
// Buffers memory words and cuts them into compressed and 32-bit instructions
`timescale 1ns/10ps

module instruction_aligner (
  input logic           i_clk,
  input logic           i_rst_n,
  fetch_word_if.aligner word,
  fetch_head_if.aligner head
);
  import fetch_pkg::*;

  // Word buffer, a small FIFO of whole memory words
  logic [WORD_BITS-1:0] slot_data [WORD_SLOTS];
  logic [XLEN-3:0]      slot_addr [WORD_SLOTS];
  logic [SLOT_BITS-1:0] rd_ptr;
  logic [SLOT_BITS-1:0] wr_ptr;
  logic [SLOT_BITS:0]   count;

  align_state_t state_q;
  align_state_t state_d;

  // Lower half of a spanning instruction and its address
  logic [PARCEL_BITS-1:0] span_lo_q;
  logic [XLEN-1:0]        span_pc_q;

  // Head word view
  logic                   have_word;
  logic [WORD_BITS-1:0]   head_word;
  logic [XLEN-1:0]        head_base;
  logic [PARCEL_BITS-1:0] lo_parcel;
  logic [PARCEL_BITS-1:0] hi_parcel;
  logic                   lo_compressed;
  logic                   hi_compressed;

  logic take;
  logic push;
  logic pop;
  logic to_span;

  assign have_word     = (count != '0);
  assign head_word     = slot_data[rd_ptr];
  assign head_base     = {slot_addr[rd_ptr], 2'b00};
  assign lo_parcel     = head_word[PARCEL_BITS-1:0];
  assign hi_parcel     = head_word[WORD_BITS-1:PARCEL_BITS];
  // Low bits 2'b11 mark a 32-bit instruction
  assign lo_compressed = (lo_parcel[1:0] != 2'b11);
  assign hi_compressed = (hi_parcel[1:0] != 2'b11);

  assign take    = head.head_valid && head.head_take;
  assign push    = word.word_valid;
  // Upper parcel opens a 32-bit instruction, move it out and free the word
  assign to_span = (state_q == ALIGN_HI_HALF) && have_word && !hi_compressed;

  // ==================================================
  // Head instruction, straight from registers
  // ==================================================
  always_comb begin
    head.head_valid      = 1'b0;
    head.head_pc         = head_base;
    head.head_instr      = head_word;
    head.head_compressed = 1'b0;
    case (state_q)
      ALIGN_IDLE: begin
        head.head_valid      = have_word;
        head.head_compressed = lo_compressed;
        if (lo_compressed) begin
          head.head_instr = {{(WORD_BITS-PARCEL_BITS){1'b0}}, lo_parcel};
        end
      end
      ALIGN_HI_HALF: begin
        head.head_valid      = have_word && hi_compressed;
        head.head_compressed = hi_compressed;
        head.head_pc         = head_base + XLEN'(PC_INC_COMPRESSED);
        head.head_instr      = {{(WORD_BITS-PARCEL_BITS){1'b0}}, hi_parcel};
      end
      ALIGN_SPAN: begin
        // Upper half is the low parcel of the new head word
        head.head_valid = have_word;
        head.head_pc    = span_pc_q;
        head.head_instr = {lo_parcel, span_lo_q};
      end
      default: ;
    endcase
  end

  // ==================================================
  // Parcel FSM and slot release
  // ==================================================
  always_comb begin
    state_d = state_q;
    pop     = 1'b0;
    case (state_q)
      ALIGN_IDLE: begin
        if (take) begin
          state_d = lo_compressed ? ALIGN_HI_HALF : ALIGN_IDLE;
          pop     = !lo_compressed;
        end else if (!have_word && push && word.word_addr[1]) begin
          // First word of a redirect to a halfword target
          state_d = ALIGN_HI_HALF;
        end
      end
      ALIGN_HI_HALF: begin
        if (take || to_span) begin
          state_d = take ? ALIGN_IDLE : ALIGN_SPAN;
          pop     = 1'b1;
        end
      end
      ALIGN_SPAN: begin
        // Low parcel used, upper half of the word still pending
        if (take) state_d = ALIGN_HI_HALF;
      end
      default: state_d = ALIGN_IDLE;
    endcase
  end

  assign word.word_credit = pop;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state_q <= ALIGN_IDLE;
      rd_ptr  <= '0;
      wr_ptr  <= '0;
      count   <= '0;
    end else if (word.flush) begin
      // Redirect drops everything buffered, including this cycle's word
      state_q <= ALIGN_IDLE;
      rd_ptr  <= '0;
      wr_ptr  <= '0;
      count   <= '0;
    end else begin
      state_q <= state_d;
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      count <= count + (SLOT_BITS+1)'(push) - (SLOT_BITS+1)'(pop);
    end
  end

  // Payload
  always_ff @(posedge i_clk) begin
    if (push) begin
      slot_data[wr_ptr] <= word.word_data;
      slot_addr[wr_ptr] <= word.word_addr[XLEN-1:2];
    end
    if (to_span) begin
      span_lo_q <= hi_parcel;
      span_pc_q <= head_base + XLEN'(PC_INC_COMPRESSED);
    end
  end

endmodule

/* source/fetch_sequencer.sv */
// Fetch sequencer
// Fetch address, memory requests, stale answer drop, credits and redirects
`timescale 1ns/10ps

module fetch_sequencer (
  input  logic                            i_clk,
  input  logic                            i_rst_n,
  input  logic                            i_imem_valid,
  input  logic [fetch_pkg::WORD_BITS-1:0] i_imem_rdata,
  input  logic                            i_redirect_valid,
  input  logic [fetch_pkg::XLEN-1:0]      i_redirect_pc,
  input  logic                            i_credit_return,
  output logic                            o_imem_req,
  output logic [fetch_pkg::XLEN-1:0]      o_imem_addr,
  output logic                            o_instr_valid,
  output logic [fetch_pkg::XLEN-1:0]      o_instr_pc,
  output logic [fetch_pkg::WORD_BITS-1:0] o_instr,
  output logic                            o_instr_compressed,
  output logic                            o_pred_taken,
  output logic [fetch_pkg::XLEN-1:0]      o_pred_target,
  fetch_word_if.sequencer                 word,
  fetch_head_if.sequencer                 head
);
  import fetch_pkg::*;

  logic [XLEN-1:0] fetch_addr_q;  // next word to request
  logic [XLEN-1:0] resp_addr_q;   // address of next kept answer, bit 1 from redirect

  // Epoch tracking, answers still owed to an abandoned path
  logic [CREDIT_BITS-1:0] pend_q;
  logic [CREDIT_BITS-1:0] stale_q;
  logic [CREDIT_BITS-1:0] wcred_q;
  logic [CREDIT_BITS-1:0] dcred_q;

  logic                   take;
  logic                   pred_redirect;
  logic                   redirect;
  logic [XLEN-1:0]        redirect_pc;
  logic                   drop;
  logic                   keep;
  logic [CREDIT_BITS-1:0] pend_d;
  logic [CREDIT_BITS-1:0] wcred_avail;
  logic                   req_d;
  logic [XLEN-1:0]        req_addr;

  // ==================================================
  // Head hand-off and redirect select
  // ==================================================
  // Execute redirect kills the head, so it never leaves
  assign head.head_take = (dcred_q != '0) && !i_redirect_valid;
  assign take           = head.head_valid && head.head_take;
  assign pred_redirect  = take && head.pred_hit;
  assign redirect       = i_redirect_valid || pred_redirect;
  assign redirect_pc    = i_redirect_valid ? i_redirect_pc : head.pred_target;

  // Answers to the current path go to the aligner
  assign drop             = i_imem_valid && (stale_q != '0);
  assign keep             = i_imem_valid && (stale_q == '0);
  assign word.word_valid  = keep;
  assign word.word_addr   = resp_addr_q;
  assign word.word_data   = i_imem_rdata;
  assign word.flush       = redirect;

  // ==================================================
  // Word credits and requests
  // ==================================================
  assign pend_d = pend_q + CREDIT_BITS'(o_imem_req) - CREDIT_BITS'(i_imem_valid);

  // After a flush the buffer is empty, stale requests keep their credit until dropped
  assign wcred_avail = redirect ? CREDIT_BITS'(WORD_SLOTS) - pend_d
                                : wcred_q + CREDIT_BITS'(word.word_credit) + CREDIT_BITS'(drop);
  assign req_d       = (wcred_avail != '0);
  assign req_addr    = redirect ? {redirect_pc[XLEN-1:2], 2'b00} : fetch_addr_q;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_imem_req    <= 1'b0;
      o_instr_valid <= 1'b0;
      fetch_addr_q  <= RESET_PC;
      resp_addr_q   <= RESET_PC;
      pend_q        <= '0;
      stale_q       <= '0;
      wcred_q       <= CREDIT_BITS'(WORD_SLOTS);
      dcred_q       <= CREDIT_BITS'(DEC_CREDITS);
    end else begin
      o_imem_req    <= req_d;
      o_instr_valid <= take;
      fetch_addr_q  <= req_d ? req_addr + XLEN'(PC_INC_FULL) : req_addr;
      pend_q        <= pend_d;
      wcred_q       <= wcred_avail - CREDIT_BITS'(req_d);
      dcred_q       <= dcred_q - CREDIT_BITS'(take) + CREDIT_BITS'(i_credit_return);
      if (redirect) begin
        // Everything still in flight belongs to the old path
        stale_q     <= pend_d;
        resp_addr_q <= {redirect_pc[XLEN-1:1], 1'b0};
      end else begin
        stale_q <= stale_q - CREDIT_BITS'(drop);
        if (keep) resp_addr_q <= {resp_addr_q[XLEN-1:2], 2'b00} + XLEN'(PC_INC_FULL);
      end
    end
  end

  // Request address and decoder payload
  always_ff @(posedge i_clk) begin
    if (req_d) o_imem_addr <= req_addr;
    if (take) begin
      o_instr_pc         <= head.head_pc;
      o_instr            <= head.head_instr;
      o_instr_compressed <= head.head_compressed;
      o_pred_taken       <= head.pred_hit;
      o_pred_target      <= head.pred_target;
    end
  end

endmodule

/* source/fetch_unit.sv */
// Instruction fetch front end
// Joins aligner, BTB and sequencer behind plain memory and decoder ports
`timescale 1ns/10ps

module fetch_unit (
  input  logic                            i_clk,
  input  logic                            i_rst_n,
  // Instruction memory
  output logic                            o_imem_req,
  output logic [fetch_pkg::XLEN-1:0]      o_imem_addr,
  input  logic                            i_imem_valid,
  input  logic [fetch_pkg::WORD_BITS-1:0] i_imem_rdata,
  // Execute redirect
  input  logic                            i_redirect_valid,
  input  logic [fetch_pkg::XLEN-1:0]      i_redirect_pc,
  // BTB update from execute
  input  logic                            i_btb_update,
  input  logic [fetch_pkg::XLEN-1:0]      i_btb_update_pc,
  input  logic [fetch_pkg::XLEN-1:0]      i_btb_update_target,
  input  logic                            i_btb_update_taken,
  // Decoder
  output logic                            o_instr_valid,
  output logic [fetch_pkg::XLEN-1:0]      o_instr_pc,
  output logic [fetch_pkg::WORD_BITS-1:0] o_instr,
  output logic                            o_instr_compressed,
  output logic                            o_pred_taken,
  output logic [fetch_pkg::XLEN-1:0]      o_pred_target,
  input  logic                            i_credit_return
);

  fetch_word_if word_bus ();
  fetch_head_if head_bus ();
  btb_update_if btb_upd ();

  // Execute update straight into the BTB bundle
  assign btb_upd.update = i_btb_update;
  assign btb_upd.pc     = i_btb_update_pc;
  assign btb_upd.target = i_btb_update_target;
  assign btb_upd.taken  = i_btb_update_taken;

  // ==================================================
  // Aligner and BTB both look at the same head
  // ==================================================
  instruction_aligner aligner_i (
    .i_clk,
    .i_rst_n,
    .word (word_bus.aligner),
    .head (head_bus.aligner)
  );

  btb_predictor btb_i (
    .i_clk,
    .i_rst_n,
    .head (head_bus.predictor),
    .upd  (btb_upd.predictor)
  );

  // Owns requests, redirects and the decoder hand-off
  fetch_sequencer sequencer_i (
    .i_clk,
    .i_rst_n,
    .i_imem_valid,
    .i_imem_rdata,
    .i_redirect_valid,
    .i_redirect_pc,
    .i_credit_return,
    .o_imem_req,
    .o_imem_addr,
    .o_instr_valid,
    .o_instr_pc,
    .o_instr,
    .o_instr_compressed,
    .o_pred_taken,
    .o_pred_target,
    .word (word_bus.sequencer),
    .head (head_bus.sequencer)
  );

endmodule

/* testbench/tb_fetch_tests.svh */
// Directed tests for the fetch front end
// Reference walk of the memory image, compare task and test tasks
`ifndef TB_FETCH_TESTS_SVH
`define TB_FETCH_TESTS_SVH

  // ==================================================
  // Reference model
  // ==================================================
  function automatic logic [15:0] parcel_at(input logic [31:0] pc);
    logic [31:0] w;
    w = read_word(pc);
    return pc[1] ? w[31:16] : w[15:0];
  endfunction

  // Any parcel not ending in 2'b11 is a compressed instruction
  function automatic logic is_compressed(input logic [31:0] pc);
    logic [15:0] lo;
    lo = parcel_at(pc);
    return (lo[1:0] != 2'b11);
  endfunction

  function automatic logic [31:0] instr_at(input logic [31:0] pc);
    logic [15:0] lo;
    lo = parcel_at(pc);
    if (lo[1:0] != 2'b11) return {16'h0000, lo};
    return {parcel_at(pc + 32'd2), lo};
  endfunction

  function automatic logic [31:0] next_pc(input logic [31:0] pc);
    return is_compressed(pc) ? pc + 32'd2 : pc + 32'd4;
  endfunction

  // ==================================================
  // Common checks and stimulus
  // ==================================================
  task automatic check_eq(input string test, input string what,
                          input logic [31:0] expected, input logic [31:0] actual);
    if (expected !== actual) begin
      err_count++;
      $display("[ERROR] %s %s: expected 0x%08h, actual 0x%08h", test, what, expected, actual);
    end
  endtask

  task automatic wait_records(input string test, input int count, input string what,
                              output bit ok);
    int waited;
    waited = 0;
    while (rec_q.size() < count && waited < WAIT_LIMIT) begin
      @(negedge i_clk);
      waited++;
    end
    ok = (rec_q.size() >= count);
    if (!ok) begin
      err_count++;
      $display("[TIMEOUT] %s: no instruction came out while waiting for %s", test, what);
    end
  endtask

  // Stamp marks the last cycle whose output may still be old path
  task automatic redirect_to(input logic [31:0] target);
    @(negedge i_clk);
    i_redirect_valid <= 1'b1;
    i_redirect_pc    <= target;
    path_cyc = cyc;
    path_idx = rec_q.size();
    @(negedge i_clk);
    i_redirect_valid <= 1'b0;
  endtask

  task automatic btb_write(input logic [31:0] pc, input logic [31:0] target, input logic taken);
    @(negedge i_clk);
    i_btb_update        <= 1'b1;
    i_btb_update_pc     <= pc;
    i_btb_update_target <= target;
    i_btb_update_taken  <= taken;
    @(negedge i_clk);
    i_btb_update <= 1'b0;
  endtask

  function automatic int count_path();
    int n;
    int i;
    n = 0;
    for (i = path_idx; i < rec_q.size(); i++) begin
      if (rec_q[i].cyc > path_cyc) n++;
    end
    return n;
  endfunction

  // Walks count instructions from start_pc, one BTB entry may be expected
  task automatic follow_path(input string name, input logic [31:0] start_pc, input int count,
                             input logic bp_en, input logic [31:0] bp_pc,
                             input logic [31:0] bp_target);
    int          idx;
    int          k;
    bit          ok;
    bit          found;
    logic [31:0] pc;
    logic        exp_taken;
    out_rec_t    r;
    idx   = path_idx;
    found = 1'b0;
    // Skip what was already on the port when the redirect was driven
    for (k = 0; k < 8 && !found; k++) begin
      wait_records(name, idx + 1, "the first instruction of the new path", ok);
      if (!ok) return;
      if (rec_q[idx].cyc > path_cyc) found = 1'b1;
      else idx++;
    end
    if (!found) begin
      err_count++;
      $display("%s: instructions of the old path kept coming after the redirect", name);
      return;
    end
    pc = start_pc;
    for (k = 0; k < count; k++) begin
      wait_records(name, idx + k + 1, "the next instruction on the path", ok);
      if (!ok) return;
      r         = rec_q[idx + k];
      exp_taken = bp_en && (pc == bp_pc);
      check_eq(name, "pc", pc, r.pc);
      check_eq(name, "instr", instr_at(pc), r.instr);
      check_eq(name, "compressed", 32'(is_compressed(pc)), 32'(r.compressed));
      check_eq(name, "pred_taken", 32'(exp_taken), 32'(r.pred_taken));
      if (exp_taken) check_eq(name, "pred_target", bp_target, r.pred_target);
      // Later compares are meaningless once the path is lost
      if (r.pc !== pc) return;
      pc = exp_taken ? bp_target : next_pc(pc);
    end
  endtask

  task automatic finish_test(input string name, input int errs_before);
    tests_run++;
    if (err_count != errs_before) begin
      tests_failed++;
      $display("[TEST] %s: %0d errors", name, err_count - errs_before);
    end else begin
      $display("[TEST] %s: ok", name);
    end
  endtask

  // ==================================================
  // Tests
  // ==================================================
  // Stream from reset covers compressed, aligned and spanning instructions
  task automatic sequential_stream();
    string name = "sequential_stream";
    int    errs;
    errs     = err_count;
    path_cyc = 0;
    path_idx = 0;
    follow_path(name, RESET_PC, 16, 1'b0, '0, '0);
    finish_test(name, errs);
  endtask

  task automatic credit_backpressure();
    string name = "credit_backpressure";
    int    errs;
    int    held;
    int    later;
    errs = err_count;
    @(negedge i_clk);
    credit_hold <= 1'b1;
    redirect_to(32'h0000_0100);
    repeat (40) @(negedge i_clk);
    held = count_path();
    check_eq(name, "instructions beyond credits", 0,
             (held > DEC_CREDITS) ? held - DEC_CREDITS : 0);
    // Nothing more may come out while returns stay withheld
    repeat (20) @(negedge i_clk);
    later = count_path();
    check_eq(name, "instructions while stalled", held, later);
    @(negedge i_clk);
    credit_hold <= 1'b0;
    follow_path(name, 32'h0000_0100, 24, 1'b0, '0, '0);
    finish_test(name, errs);
  endtask

  // Word aligned, halfword and back to back redirects
  task automatic execute_redirect();
    string       name = "execute_redirect";
    int          errs;
    int          i;
    logic [31:0] targets [3];
    errs       = err_count;
    targets[0] = 32'h0000_0200;
    targets[1] = 32'h0000_0306;
    targets[2] = 32'h0000_0002;
    for (i = 0; i < 3; i++) begin
      redirect_to(targets[i]);
      follow_path(name, targets[i], 10, 1'b0, '0, '0);
    end
    redirect_to(32'h0000_0400);
    redirect_to(32'h0000_050a);
    follow_path(name, 32'h0000_050a, 10, 1'b0, '0, '0);
    finish_test(name, errs);
  endtask

  // Taken entry on a spanning instruction, then cleared by a not taken update
  task automatic branch_prediction();
    string       name = "branch_prediction";
    int          errs;
    logic [31:0] p;
    logic [31:0] t;
    errs = err_count;
    p    = 32'h0000_000e;
    t    = 32'h0000_0242;
    btb_write(p, t, 1'b1);
    redirect_to(32'h0000_0000);
    follow_path(name, 32'h0000_0000, 12, 1'b1, p, t);
    btb_write(p, t, 1'b0);
    redirect_to(32'h0000_0000);
    follow_path(name, 32'h0000_0000, 12, 1'b0, p, t);
    finish_test(name, errs);
  endtask

  // Same index, other tag
  task automatic alias_eviction();
    string       name = "alias_eviction";
    int          errs;
    logic [31:0] p;
    logic [31:0] q;
    errs = err_count;
    p    = 32'h0000_000e;
    q    = p + 32'h0000_1000;
    btb_write(p, 32'h0000_0242, 1'b1);
    btb_write(q, 32'h0000_0384, 1'b1);
    redirect_to(32'h0000_0000);
    follow_path(name, 32'h0000_0000, 12, 1'b0, p, 32'h0000_0242);
    // The alias owns the line now
    redirect_to(q);
    follow_path(name, q, 6, 1'b1, q, 32'h0000_0384);
    finish_test(name, errs);
  endtask

`endif

/* testbench/tb_fetch_unit.sv */
// Testbench for the fetch front end
// Clock, reset, sparse memory model, decoder credit model and output monitor
`timescale 1ns/10ps

module tb_fetch_unit;
  import fetch_pkg::*;

  // Bound on every wait, in cycles
  localparam int unsigned WAIT_LIMIT = 200;
  localparam logic [31:0] SEED       = 32'h3db8_c5a0;

  // One instruction seen on the decoder port
  typedef struct packed {
    logic [31:0] cyc;
    logic [31:0] pc;
    logic [31:0] instr;
    logic        compressed;
    logic        pred_taken;
    logic [31:0] pred_target;
  } out_rec_t;

  logic        i_clk;
  logic        i_rst_n;
  logic        i_imem_valid = 1'b0;
  logic [31:0] i_imem_rdata = '0;
  logic        i_redirect_valid;
  logic [31:0] i_redirect_pc;
  logic        i_btb_update;
  logic [31:0] i_btb_update_pc;
  logic [31:0] i_btb_update_target;
  logic        i_btb_update_taken;
  logic        i_credit_return = 1'b0;
  logic        o_imem_req;
  logic [31:0] o_imem_addr;
  logic        o_instr_valid;
  logic [31:0] o_instr_pc;
  logic [31:0] o_instr;
  logic        o_instr_compressed;
  logic        o_pred_taken;
  logic [31:0] o_pred_target;

  // Sparse word memory keyed by word index, requests in flight in order
  logic [31:0] mem [int unsigned];
  logic [31:0] req_addr_q [$];
  int unsigned req_due_q [$];
  int unsigned last_due;
  int unsigned cyc = 0;

  // Decoder side
  logic        credit_hold;
  int unsigned owed;
  out_rec_t    rec_q [$];
  out_rec_t    mon_rec;

  // Scoreboard state shared by the tests
  int unsigned path_cyc;
  int          path_idx;
  int          err_count;
  int          tests_run;
  int          tests_failed;

  fetch_unit dut_i (.*);

  // ==================================================
  // Memory image
  // ==================================================
  // Unwritten words follow a pattern built from the whole word address
  function automatic logic [31:0] read_word(input logic [31:0] addr);
    if (mem.exists(addr[31:2])) return mem[addr[31:2]];
    return {addr[17:2], addr[31:18], 2'b01};
  endfunction

  task automatic put_parcel(input logic [31:0] addr, input logic [15:0] val);
    logic [31:0] w;
    w = read_word(addr);
    if (addr[1]) w[31:16] = val;
    else w[15:0] = val;
    mem[addr[31:2]] = w;
  endtask

  // Low bits 2'b11 mean two parcels
  task automatic put_instr(input logic [31:0] addr, input logic [31:0] instr);
    put_parcel(addr, instr[15:0]);
    if (instr[1:0] == 2'b11) put_parcel(addr + 32'd2, instr[31:16]);
  endtask

  // Mixed program at the reset address, three 32-bit ones span two words
  task automatic load_program();
    put_instr(32'h00, 32'h0000_4501);
    put_instr(32'h02, 32'h00a0_0593);
    put_instr(32'h06, 32'h0000_0505);
    put_instr(32'h08, 32'h00b5_0633);
    put_instr(32'h0c, 32'h0000_852e);
    put_instr(32'h0e, 32'hfe00_0ee3);
    put_instr(32'h12, 32'h0000_0001);
    put_instr(32'h14, 32'h0000_4581);
    put_instr(32'h16, 32'h00c5_8533);
    put_instr(32'h1a, 32'h0000_0586);
    put_instr(32'h1c, 32'h0000_0013);
  endtask

  `include "tb_fetch_tests.svh"

  // ==================================================
  // Clock, cycle count and models
  // ==================================================
  initial begin
    i_clk = 1'b0;
    forever #4 i_clk = ~i_clk;
  end

  always @(posedge i_clk) cyc <= cyc + 1;

  // Answers in order, one cycle after the request plus 0 to 2 extra
  always @(negedge i_clk) begin : imem_model
    int unsigned due;
    if (!i_rst_n) begin
      i_imem_valid <= 1'b0;
      req_addr_q.delete();
      req_due_q.delete();
      last_due = 0;
    end else begin
      if (o_imem_req) begin
        // Requests are whole words
        check_eq("imem_model", "request address bits 1:0", 32'd0, 32'(o_imem_addr[1:0]));
        due = cyc + 1 + ($urandom % 3);
        if (due <= last_due) due = last_due + 1;
        last_due = due;
        req_addr_q.push_back(o_imem_addr);
        req_due_q.push_back(due);
      end
      if (req_due_q.size() != 0 && req_due_q[0] <= cyc) begin
        i_imem_valid <= 1'b1;
        i_imem_rdata <= read_word(req_addr_q.pop_front());
        void'(req_due_q.pop_front());
      end else begin
        i_imem_valid <= 1'b0;
      end
    end
  end

  // Decoder gives back one credit per cycle unless held
  always @(negedge i_clk) begin : decoder_model
    int unsigned pending;
    if (!i_rst_n) begin
      owed = 0;
      i_credit_return <= 1'b0;
    end else begin
      pending = owed + (o_instr_valid ? 1 : 0);
      if (!credit_hold && pending != 0) begin
        i_credit_return <= 1'b1;
        pending--;
      end else begin
        i_credit_return <= 1'b0;
      end
      owed = pending;
    end
  end

  // Monitor logs every instruction with the cycle it was seen
  always @(negedge i_clk) begin
    if (i_rst_n && o_instr_valid) begin
      mon_rec.cyc         = cyc;
      mon_rec.pc          = o_instr_pc;
      mon_rec.instr       = o_instr;
      mon_rec.compressed  = o_instr_compressed;
      mon_rec.pred_taken  = o_pred_taken;
      mon_rec.pred_target = o_pred_target;
      rec_q.push_back(mon_rec);
      $display("[MON] cycle %0d pc 0x%08h instr 0x%08h rvc %0b taken %0b target 0x%08h",
               cyc, o_instr_pc, o_instr, o_instr_compressed, o_pred_taken, o_pred_target);
    end
  end

  // ==================================================
  // Test sequence
  // ==================================================
  initial begin
    void'($urandom(SEED));
    i_rst_n             = 1'b0;
    i_redirect_valid    = 1'b0;
    i_redirect_pc       = '0;
    i_btb_update        = 1'b0;
    i_btb_update_pc     = '0;
    i_btb_update_target = '0;
    i_btb_update_taken  = 1'b0;
    credit_hold         = 1'b0;
    path_cyc            = 0;
    path_idx            = 0;
    err_count           = 0;
    tests_run           = 0;
    tests_failed        = 0;
    load_program();
    repeat (3) @(posedge i_clk);
    @(negedge i_clk);
    // Quiet memory and decoder ports under reset
    check_eq("reset", "o_imem_req", 32'd0, 32'(o_imem_req));
    check_eq("reset", "o_instr_valid", 32'd0, 32'(o_instr_valid));
    i_rst_n <= 1'b1;

    sequential_stream();
    credit_backpressure();
    execute_redirect();
    branch_prediction();
    alias_eviction();

    $display("Tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, err_count);
    if (err_count == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

/* fetch_unit.f */
+incdir+testbench
common/fetch_pkg.sv
common/predict_pkg.sv
common/fetch_ifs.sv
btb/btb_predictor.sv
aligner/instruction_aligner.sv
source/fetch_sequencer.sv
source/fetch_unit.sv
testbench/tb_fetch_unit.sv

/* Makefile */
# Verilator simulation of the fetch front end testbench

SIM      := verilator
FLAGS    := --binary --timing -j 0 -Wno-fatal
TOP      := tb_fetch_unit
FILELIST := fetch_unit.f
BUILD    := obj_dir
LOG      := sim.log
PASS_MSG := All tests passed

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
